// File: decode_pkg.sv
package decode_pkg;

	localparam int DATA_W = 32;
	localparam int OPCODE_W = 6;
	localparam int SUB_BASE_W = 5;
	localparam int SUB_LS_W = 8;
	localparam int SUB_JR_W = 5;
	localparam int SUB_MISC_W = 5;

	// major opcodes
	typedef enum logic [OPCODE_W-1:0] {
		TY_BASE = 6'h20,
		ADDI    = 6'h28,
		SUBRI   = 6'h29,
		ANDI    = 6'h2a,
		XORI    = 6'h2b,
		ORI     = 6'h2c,
		SLTI    = 6'h2e,
		SLTSI   = 6'h2f,
		MOVI    = 6'h22,
		SETHI   = 6'h23,
		LWI     = 6'h02,
		SWI     = 6'h0a,
		LWIBI   = 6'h06,
		SWIBI   = 6'h0e,
		TY_LS   = 6'h1c,
		TY_B    = 6'h26,
		TY_J    = 6'h24,
		TY_JR   = 6'h25,
		TY_MISC = 6'h32
	} opcode_t;

	typedef enum logic [SUB_BASE_W-1:0] {
		ADD   = 5'h00,
		SUB   = 5'h01,
		AND   = 5'h02,
		XOR   = 5'h03,
		OR    = 5'h04,
		SLT   = 5'h06,
		SLTS  = 5'h07,
		SLLI  = 5'h08,
		SRLI  = 5'h09,
		ROTRI = 5'h0b,
		SLL   = 5'h0c,
		SRL   = 5'h0d,
		SEB   = 5'h10,
		SEH   = 5'h11,
		CMOVZ = 5'h1a,
		CMOVN = 5'h1b
	} sub_base_t;

	typedef enum logic [SUB_LS_W-1:0] {LW = 8'h02, SW = 8'h0a} sub_ls_t;
	typedef enum logic {J = 1'b0, JAL = 1'b1} sub_j_t;
	typedef enum logic [SUB_JR_W-1:0] {JR = 5'h00, JRAL = 5'h01} sub_jr_t;

	typedef enum logic [SUB_MISC_W-1:0] {
		MFSR    = 5'h02,
		MTSR    = 5'h03,
		IRET    = 5'h04,
		SYSCALL = 5'h0b
	} sub_misc_t;

	// instructions with identical control words share a class
	typedef enum logic [4:0] {
		ALU_REG, ALU_UNARY, SHIFT_IMM, CMOV,
		ALU_IMM_SE, ALU_IMM_ZE, MOV_IMM, SET_HI,
		LOAD_I, STORE_I, LOAD_BI, STORE_BI, LOAD_REG, STORE_REG,
		BRANCH, JUMP_LINK, JUMP_REG_LINK,
		SYS_MT, SYS_MF, SYS_CALL, SYS_IRET,
		ILLEGAL
	} insn_class_t;

	typedef enum logic [2:0] {
		ALUSRC2_NONE, ALUSRC2_RBDATA, ALUSRC2_IMM, ALUSRC2_LSWI, ALUSRC2_LSW, ALUSRC2_BENX
	} alu_src2_t;

	typedef enum logic [2:0] {
		IMM_NONE, IMM_5BIT_ZE, IMM_15BIT_SE, IMM_15BIT_ZE, IMM_20BIT_SE, IMM_20BIT_HI
	} imm_ext_t;

	typedef enum logic {MADDR_ALURESULT, MADDR_RADATA} mem_addr_sel_t;

	typedef enum logic [1:0] {WRADDR_NONE, WRADDR_RT, WRADDR_LP} wr_addr_sel_t;

	typedef enum logic [2:0] {
		WRREG_NONE, WRREG_ALURESULT, WRREG_CMOV, WRREG_IMMDATA,
		WRREG_MEM, WRREG_PC, WRREG_RTDATA, WRREG_SYSREG
	} wr_src_sel_t;

	typedef enum logic [1:0] {MISC_NONE, MISC_MTSR, MISC_MFSR, MISC_SYSCALL} misc_sel_t;
	// iret shares the idle code, do_misc marks it
	localparam misc_sel_t MISC_IRET = MISC_NONE;

	typedef struct packed {
		logic [OPCODE_W-1:0] opcode;
		logic [SUB_BASE_W-1:0] sub_op_base;
		logic [SUB_LS_W-1:0] sub_op_ls;
		logic sub_op_j;
		logic [SUB_JR_W-1:0] sub_op_jr;
		logic [SUB_MISC_W-1:0] sub_op_misc;
		logic [DATA_W-1:0] rt_data;
		logic [DATA_W-1:0] ra_data;
	} decode_req_t;

	typedef struct packed {
		logic rt_ra_equal;
		logic rt_zero;
		logic rt_negative;
	} cmp_flags_t;

	typedef struct packed {
		insn_class_t insn_class;
		cmp_flags_t flags;
	} class_word_t;

	typedef struct packed {
		alu_src2_t sel_alu_src2;
		imm_ext_t sel_imm_ext;
		mem_addr_sel_t sel_mem_addr;
		wr_addr_sel_t sel_wr_addr;
		wr_src_sel_t sel_wr_src;
		misc_sel_t sel_misc;
		logic do_misc;
		logic do_dm_read;
		logic do_dm_write;
		logic do_reg_write;
		logic do_ra_write;
	} ctrl_word_t;

	typedef struct packed {
		ctrl_word_t ctrl;
		cmp_flags_t flags;
	} decode_resp_t;

	localparam ctrl_word_t CTRL_IDLE = '{
		sel_alu_src2: ALUSRC2_NONE,
		sel_imm_ext: IMM_NONE,
		sel_mem_addr: MADDR_ALURESULT,
		sel_wr_addr: WRADDR_NONE,
		sel_wr_src: WRREG_NONE,
		sel_misc: MISC_NONE,
		do_misc: 1'b0,
		do_dm_read: 1'b0,
		do_dm_write: 1'b0,
		do_reg_write: 1'b0,
		do_ra_write: 1'b0
	};

endpackage

// File: pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input logic clock,
	input logic reset,
	input payload_t in_data,
	input logic in_valid,
	output logic in_ready,
	output payload_t out_data,
	output logic out_valid,
	input logic out_ready
);

	logic load;

	// accept when empty or when the held item leaves this edge
	assign in_ready = !out_valid || out_ready;
	assign load = in_valid && in_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			out_data <= in_data;
		end
	end

endmodule

// File: op_classify.sv
`timescale 1ns/1ps

module op_classify (
	input decode_pkg::decode_req_t req,
	output decode_pkg::class_word_t cls
);

	import decode_pkg::*;

	insn_class_t insn;

	always_comb begin
		insn = ILLEGAL;
		case (req.opcode)
			TY_BASE: begin
				case (req.sub_op_base)
					ADD, SUB, AND, OR, XOR, SLT, SLTS, SRL, SLL: begin
						insn = ALU_REG;
					end
					SEB, SEH: begin
						insn = ALU_UNARY;
					end
					SRLI, SLLI, ROTRI: begin
						insn = SHIFT_IMM;
					end
					CMOVN, CMOVZ: begin
						insn = CMOV;
					end
					default: begin
						insn = ILLEGAL;
					end
				endcase
			end
			ADDI, SUBRI, SLTI, SLTSI: begin
				insn = ALU_IMM_SE;
			end
			ANDI, ORI, XORI: begin
				insn = ALU_IMM_ZE;
			end
			MOVI: insn = MOV_IMM;
			SETHI: insn = SET_HI;
			LWI: insn = LOAD_I;
			SWI: insn = STORE_I;
			LWIBI: insn = LOAD_BI;
			SWIBI: insn = STORE_BI;
			TY_LS: begin
				case (req.sub_op_ls)
					LW: insn = LOAD_REG;
					SW: insn = STORE_REG;
					default: insn = ILLEGAL;
				endcase
			end
			TY_B: insn = BRANCH;
			TY_J: begin
				case (req.sub_op_j)
					JAL: insn = JUMP_LINK;
					// plain jump has no control word of its own
					J: insn = ILLEGAL;
				endcase
			end
			TY_JR: begin
				case (req.sub_op_jr)
					JRAL: insn = JUMP_REG_LINK;
					JR: insn = ILLEGAL;
					default: insn = ILLEGAL;
				endcase
			end
			TY_MISC: begin
				case (req.sub_op_misc)
					MTSR: insn = SYS_MT;
					MFSR: insn = SYS_MF;
					SYSCALL: insn = SYS_CALL;
					IRET: insn = SYS_IRET;
					default: insn = ILLEGAL;
				endcase
			end
			default: begin
				insn = ILLEGAL;
			end
		endcase
	end

	assign cls.insn_class = insn;

	// branch compare flags
	assign cls.flags.rt_ra_equal = (req.rt_data == req.ra_data);
	assign cls.flags.rt_zero = ~|req.rt_data;
	assign cls.flags.rt_negative = req.rt_data[DATA_W-1];

endmodule

// File: ctrl_expand.sv
`timescale 1ns/1ps

module ctrl_expand (
	input decode_pkg::class_word_t cls,
	output decode_pkg::decode_resp_t resp
);

	import decode_pkg::*;

	ctrl_word_t ctrl;

	always_comb begin
		ctrl = CTRL_IDLE;
		case (cls.insn_class)
			ALU_REG: begin
				ctrl.sel_alu_src2 = ALUSRC2_RBDATA;
				ctrl.sel_wr_addr = WRADDR_RT;
				ctrl.sel_wr_src = WRREG_ALURESULT;
				ctrl.do_reg_write = 1'b1;
			end
			// seb and seh take no second operand
			ALU_UNARY: begin
				ctrl.sel_wr_addr = WRADDR_RT;
				ctrl.sel_wr_src = WRREG_ALURESULT;
				ctrl.do_reg_write = 1'b1;
			end
			SHIFT_IMM: begin
				ctrl.sel_alu_src2 = ALUSRC2_IMM;
				ctrl.sel_imm_ext = IMM_5BIT_ZE;
				ctrl.sel_wr_addr = WRADDR_RT;
				ctrl.sel_wr_src = WRREG_ALURESULT;
				ctrl.do_reg_write = 1'b1;
			end
			CMOV: begin
				ctrl.sel_wr_addr = WRADDR_RT;
				ctrl.sel_wr_src = WRREG_CMOV;
				ctrl.do_reg_write = 1'b1;
			end
			ALU_IMM_SE, ALU_IMM_ZE: begin
				ctrl.sel_alu_src2 = ALUSRC2_IMM;
				ctrl.sel_imm_ext = (cls.insn_class == ALU_IMM_SE) ? IMM_15BIT_SE : IMM_15BIT_ZE;
				ctrl.sel_wr_addr = WRADDR_RT;
				ctrl.sel_wr_src = WRREG_ALURESULT;
				ctrl.do_reg_write = 1'b1;
			end
			MOV_IMM, SET_HI: begin
				ctrl.sel_imm_ext = (cls.insn_class == MOV_IMM) ? IMM_20BIT_SE : IMM_20BIT_HI;
				ctrl.sel_wr_addr = WRADDR_RT;
				ctrl.sel_wr_src = WRREG_IMMDATA;
				ctrl.do_reg_write = 1'b1;
			end
			LOAD_I, LOAD_BI, LOAD_REG: begin
				ctrl.sel_alu_src2 = (cls.insn_class == LOAD_REG) ? ALUSRC2_LSW : ALUSRC2_LSWI;
				// post-increment loads address memory with the old base
				if (cls.insn_class == LOAD_BI) begin
					ctrl.sel_mem_addr = MADDR_RADATA;
					ctrl.do_ra_write = 1'b1;
				end
				ctrl.sel_wr_addr = WRADDR_RT;
				ctrl.sel_wr_src = WRREG_MEM;
				ctrl.do_dm_read = 1'b1;
				ctrl.do_reg_write = 1'b1;
			end
			STORE_I, STORE_BI, STORE_REG: begin
				ctrl.sel_alu_src2 = (cls.insn_class == STORE_REG) ? ALUSRC2_LSW : ALUSRC2_LSWI;
				if (cls.insn_class == STORE_BI) begin
					ctrl.sel_mem_addr = MADDR_RADATA;
					ctrl.do_ra_write = 1'b1;
				end
				ctrl.do_dm_write = 1'b1;
			end
			BRANCH: begin
				ctrl.sel_alu_src2 = ALUSRC2_BENX;
			end
			JUMP_LINK: begin
				ctrl.sel_wr_addr = WRADDR_LP;
				ctrl.sel_wr_src = WRREG_PC;
				ctrl.do_reg_write = 1'b1;
			end
			JUMP_REG_LINK: begin
				ctrl.sel_wr_addr = WRADDR_RT;
				ctrl.sel_wr_src = WRREG_PC;
				ctrl.do_reg_write = 1'b1;
			end
			// rt data goes to the system register, no gpr write
			SYS_MT: begin
				ctrl.sel_wr_src = WRREG_RTDATA;
				ctrl.sel_misc = MISC_MTSR;
				ctrl.do_misc = 1'b1;
			end
			SYS_MF: begin
				ctrl.sel_wr_addr = WRADDR_RT;
				ctrl.sel_wr_src = WRREG_SYSREG;
				ctrl.sel_misc = MISC_MFSR;
				ctrl.do_misc = 1'b1;
				ctrl.do_reg_write = 1'b1;
			end
			SYS_CALL: begin
				ctrl.sel_misc = MISC_SYSCALL;
				ctrl.do_misc = 1'b1;
			end
			SYS_IRET: begin
				ctrl.sel_misc = MISC_IRET;
				ctrl.do_misc = 1'b1;
			end
			default: begin
				ctrl = CTRL_IDLE;
			end
		endcase
	end

	assign resp.ctrl = ctrl;
	assign resp.flags = cls.flags;

endmodule

// File: decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
	input logic clock,
	input logic reset,
	input decode_pkg::decode_req_t req,
	input logic req_valid,
	output logic req_ready,
	output decode_pkg::decode_resp_t resp,
	output logic resp_valid,
	input logic resp_ready
);

	import decode_pkg::*;

	class_word_t cls_d;
	class_word_t cls_q;
	logic cls_valid;
	logic cls_ready;
	decode_resp_t resp_d;

	op_classify op_classify_i (
		.req(req),
		.cls(cls_d)
	);

	// stage 1 holds the class and flags
	pipe_reg #(.payload_t(class_word_t)) class_reg_i (
		.clock(clock),
		.reset(reset),
		.in_data(cls_d),
		.in_valid(req_valid),
		.in_ready(req_ready),
		.out_data(cls_q),
		.out_valid(cls_valid),
		.out_ready(cls_ready)
	);

	ctrl_expand ctrl_expand_i (
		.cls(cls_q),
		.resp(resp_d)
	);

	// stage 2 holds the full response
	pipe_reg #(.payload_t(decode_resp_t)) resp_reg_i (
		.clock(clock),
		.reset(reset),
		.in_data(resp_d),
		.in_valid(cls_valid),
		.in_ready(cls_ready),
		.out_data(resp),
		.out_valid(resp_valid),
		.out_ready(resp_ready)
	);

endmodule

// File: decode_unit_props.sv
`timescale 1ns/1ps

module decode_unit_props (
	input logic clock,
	input logic reset,
	input decode_pkg::decode_resp_t resp,
	input logic resp_valid,
	input logic resp_ready
);

	// nothing leaves the unit right after reset
	a_idle_after_reset: assert property (@(posedge clock) reset |=> !resp_valid)
		else $error("resp_valid high in the cycle after reset");

	a_hold_stable: assert property (@(posedge clock) disable iff (reset)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp))
		else $error("response changed or dropped while stalled");

	a_no_read_and_write: assert property (@(posedge clock) disable iff (reset)
		resp_valid |-> !(resp.ctrl.do_dm_read && resp.ctrl.do_dm_write))
		else $error("data memory read and write both enabled");

	// base update only with a memory access
	a_ra_write_needs_mem: assert property (@(posedge clock) disable iff (reset)
		resp_valid && resp.ctrl.do_ra_write |->
			resp.ctrl.do_dm_read || resp.ctrl.do_dm_write)
		else $error("ra write without a memory access");

endmodule

bind decode_unit decode_unit_props props_i (.*);

// File: tb_decode_unit.sv
`timescale 1ns/1ps

module tb_decode_unit;

	import decode_pkg::*;

	localparam int NUM_REQ = 3000;
	localparam int PHASE1_REQ = 500;
	localparam int MAX_CYCLES = NUM_REQ * 4;

	logic clock;
	logic reset;
	decode_req_t req;
	logic req_valid;
	logic req_ready;
	decode_resp_t resp;
	logic resp_valid;
	logic resp_ready;

	decode_resp_t exp_q[$];
	int acc_q[$];
	int cycles;
	int received;
	int value_errors;
	int timing_errors;
	int order_errors;
	logic bp_on;

	opcode_t ops[19] = '{TY_BASE, ADDI, SUBRI, ANDI, ORI, XORI, SLTI, SLTSI, MOVI, SETHI,
		LWI, SWI, LWIBI, SWIBI, TY_LS, TY_B, TY_J, TY_JR, TY_MISC};
	sub_base_t bases[16] = '{ADD, SUB, AND, OR, XOR, SEB, SEH, SLT, SLTS, SRL, SLL,
		SRLI, SLLI, ROTRI, CMOVN, CMOVZ};
	sub_misc_t miscs[4] = '{MTSR, MFSR, SYSCALL, IRET};

	decode_unit decode_unit_i (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic ctrl_word_t wb(ctrl_word_t c, wr_addr_sel_t a, wr_src_sel_t s);
		c.sel_wr_addr = a;
		c.sel_wr_src = s;
		c.do_reg_write = 1'b1;
		return c;
	endfunction

	// expected response straight from opcode and sub-op
	function automatic decode_resp_t model(decode_req_t r);
		decode_resp_t e;
		e = '0;
		case (r.opcode)
			TY_BASE: case (r.sub_op_base)
				ADD, SUB, AND, OR, XOR, SLT, SLTS, SRL, SLL: begin
					e.ctrl = wb(e.ctrl, WRADDR_RT, WRREG_ALURESULT);
					e.ctrl.sel_alu_src2 = ALUSRC2_RBDATA;
				end
				SEB, SEH: e.ctrl = wb(e.ctrl, WRADDR_RT, WRREG_ALURESULT);
				SRLI, SLLI, ROTRI: begin
					e.ctrl = wb(e.ctrl, WRADDR_RT, WRREG_ALURESULT);
					e.ctrl.sel_alu_src2 = ALUSRC2_IMM;
					e.ctrl.sel_imm_ext = IMM_5BIT_ZE;
				end
				CMOVN, CMOVZ: e.ctrl = wb(e.ctrl, WRADDR_RT, WRREG_CMOV);
				default: ;
			endcase
			ADDI, SUBRI, SLTI, SLTSI, ANDI, ORI, XORI: begin
				e.ctrl = wb(e.ctrl, WRADDR_RT, WRREG_ALURESULT);
				e.ctrl.sel_alu_src2 = ALUSRC2_IMM;
				e.ctrl.sel_imm_ext = (r.opcode == ANDI || r.opcode == ORI ||
					r.opcode == XORI) ? IMM_15BIT_ZE : IMM_15BIT_SE;
			end
			MOVI, SETHI: begin
				e.ctrl = wb(e.ctrl, WRADDR_RT, WRREG_IMMDATA);
				e.ctrl.sel_imm_ext = (r.opcode == MOVI) ? IMM_20BIT_SE : IMM_20BIT_HI;
			end
			LWI, LWIBI: begin
				e.ctrl = wb(e.ctrl, WRADDR_RT, WRREG_MEM);
				e.ctrl.sel_alu_src2 = ALUSRC2_LSWI;
				e.ctrl.do_dm_read = 1'b1;
				e.ctrl.sel_mem_addr = (r.opcode == LWIBI) ? MADDR_RADATA : MADDR_ALURESULT;
				e.ctrl.do_ra_write = (r.opcode == LWIBI);
			end
			SWI, SWIBI: begin
				e.ctrl.sel_alu_src2 = ALUSRC2_LSWI;
				e.ctrl.do_dm_write = 1'b1;
				e.ctrl.sel_mem_addr = (r.opcode == SWIBI) ? MADDR_RADATA : MADDR_ALURESULT;
				e.ctrl.do_ra_write = (r.opcode == SWIBI);
			end
			TY_LS: begin
				if (r.sub_op_ls == LW) begin
					e.ctrl = wb(e.ctrl, WRADDR_RT, WRREG_MEM);
					e.ctrl.sel_alu_src2 = ALUSRC2_LSW;
					e.ctrl.do_dm_read = 1'b1;
				end else if (r.sub_op_ls == SW) begin
					e.ctrl.sel_alu_src2 = ALUSRC2_LSW;
					e.ctrl.do_dm_write = 1'b1;
				end
			end
			TY_B: e.ctrl.sel_alu_src2 = ALUSRC2_BENX;
			TY_J: if (r.sub_op_j == JAL) e.ctrl = wb(e.ctrl, WRADDR_LP, WRREG_PC);
			TY_JR: if (r.sub_op_jr == JRAL) e.ctrl = wb(e.ctrl, WRADDR_RT, WRREG_PC);
			TY_MISC: case (r.sub_op_misc)
				MTSR: begin
					e.ctrl.sel_wr_src = WRREG_RTDATA;
					e.ctrl.sel_misc = MISC_MTSR;
					e.ctrl.do_misc = 1'b1;
				end
				MFSR: begin
					e.ctrl = wb(e.ctrl, WRADDR_RT, WRREG_SYSREG);
					e.ctrl.sel_misc = MISC_MFSR;
					e.ctrl.do_misc = 1'b1;
				end
				SYSCALL: begin
					e.ctrl.sel_misc = MISC_SYSCALL;
					e.ctrl.do_misc = 1'b1;
				end
				// iret keeps the idle select code
				IRET: e.ctrl.do_misc = 1'b1;
				default: ;
			endcase
			default: ;
		endcase
		e.flags.rt_ra_equal = (r.rt_data == r.ra_data);
		e.flags.rt_zero = (r.rt_data == 32'd0);
		e.flags.rt_negative = r.rt_data[31];
		return e;
	endfunction

	function automatic decode_req_t make_req();
		decode_req_t r;
		r.opcode = ops[$urandom % 19];
		r.sub_op_base = bases[$urandom % 16];
		r.sub_op_ls = ($urandom % 2) ? LW : SW;
		r.sub_op_j = 1'($urandom);
		r.sub_op_jr = ($urandom % 2) ? JR : JRAL;
		r.sub_op_misc = miscs[$urandom % 4];
		r.rt_data = $urandom;
		r.ra_data = $urandom;
		// roughly one in ten gets raw fields
		if ($urandom % 10 == 0) begin
			r.sub_op_base = SUB_BASE_W'($urandom);
			r.sub_op_ls = SUB_LS_W'($urandom);
			r.sub_op_jr = SUB_JR_W'($urandom);
			r.sub_op_misc = SUB_MISC_W'($urandom);
			if ($urandom % 2) r.opcode = OPCODE_W'($urandom);
		end
		case ($urandom % 4)
			0: r.ra_data = r.rt_data;
			1: r.rt_data = '0;
			2: r.rt_data[31] = 1'b1;
			default: ;
		endcase
		return r;
	endfunction

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, %0d of %0d responses seen",
				cycles, received, NUM_REQ);
			$display("Done: errors found");
			$finish;
		end
	end

	// scoreboard sees the values from before the edge updates
	always @(posedge clock) begin
		if (!reset && req_valid && req_ready) begin
			exp_q.push_back(model(req));
			acc_q.push_back(cycles);
		end
		if (!reset && resp_valid && resp_ready) begin
			received <= received + 1;
			if (exp_q.size() == 0) begin
				order_errors++;
				$display("response seen at %0t with no request outstanding", $time);
			end else begin
				assert (resp === exp_q[0])
				else begin
					value_errors++;
					$display("ERR %0t: resp %h, expected %h", $time, resp, exp_q[0]);
				end
				assert (bp_on || cycles - acc_q[0] == 2)
				else begin
					timing_errors++;
					$display("ERR %0t: latency %0d cycles, expected 2", $time,
						cycles - acc_q[0]);
				end
				void'(exp_q.pop_front());
				void'(acc_q.pop_front());
			end
		end
	end

	initial begin
		forever begin
			@(posedge clock);
			#1;
			resp_ready = bp_on ? ($urandom % 3 != 0) : 1'b1;
		end
	end

	initial begin
		void'($urandom(32'h793c7997));
		reset = 1'b1;
		req = '0;
		req_valid = 1'b0;
		resp_ready = 1'b1;
		bp_on = 1'b0;
		cycles = 0;
		received = 0;
		value_errors = 0;
		timing_errors = 0;
		order_errors = 0;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
		assert (!resp_valid && req_ready)
		else begin
			order_errors++;
			$display("ERR %0t: after reset resp_valid %b req_ready %b", $time,
				resp_valid, req_ready);
		end
		for (int i = 0; i < NUM_REQ; i++) begin
			// drain and then switch on back-pressure
			if (i == PHASE1_REQ) begin
				req_valid = 1'b0;
				while (exp_q.size() != 0) @(posedge clock);
				#1;
				bp_on = 1'b1;
			end
			if ($urandom % 5 == 0) begin
				req_valid = 1'b0;
				@(posedge clock);
				#1;
			end
			req = make_req();
			req_valid = 1'b1;
			do @(posedge clock); while (!req_ready);
			#1;
		end
		req_valid = 1'b0;
		while (received < NUM_REQ) @(posedge clock);
		@(posedge clock);
		$display("value errors %0d, latency errors %0d, other errors %0d",
			value_errors, timing_errors, order_errors);
		if (value_errors + timing_errors + order_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: src.f
decode_pkg.sv
pipe_reg.sv
op_classify.sv
ctrl_expand.sv
decode_unit.sv
decode_unit_props.sv
tb_decode_unit.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_decode_unit
FILELIST = src.f
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Done: no errors"

clean:
	rm -rf $(OBJ_DIR)
